// File: design/adc_sipo.sv
// ADC serial sample shifter
module adc_sipo (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              data_in,
    input  logic              bit_valid,
    input  logic              data_logging,
    output pool_pkg::sample_t data_out
);

    import pool_pkg::*;

    // a bit is only taken while logging is enabled
    logic shift_en;

    assign shift_en = bit_valid & data_logging;

    // msb arrives first, so older bits move toward the top
    // the register keeps the last full sample between bursts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (shift_en) begin
            data_out <= {data_out[sample_bits-2:0], data_in};
        end
    end

endmodule

// File: design/pool_datapath.sv
// Peak hold and report byte datapath
module pool_datapath #(
    parameter int tick_cycles = 6_250_000,
    parameter int peak_window = 40
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                adc_bit,
    input  logic                adc_bit_valid,
    input  logic                data_logging,
    input  logic                data_ready,
    input  logic                frame_busy,
    input  pool_pkg::word_sel_t word_sel,
    output logic [7:0]          tx_word
);

    import pool_pkg::*;

    // latest full sample out of the shifter
    sample_t sample;
    // running maximum since the last window clear
    sample_t peak;
    // copy of peak that stays put while a frame is sent
    sample_t snapshot;

    logic                   tick;
    logic [window_bits-1:0] window_cnt;
    logic                   window_clear;

    adc_sipo adc_sipo_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_in      (adc_bit),
        .bit_valid    (adc_bit_valid),
        .data_logging (data_logging),
        .data_out     (sample)
    );

    tick_divider #(
        .tick_cycles (tick_cycles)
    ) tick_divider_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    // window end, counter and peak both drop at the next edge
    assign window_clear = (window_cnt >= window_bits'(peak_window));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_cnt <= '0;
        end else if (window_clear) begin
            window_cnt <= '0;
        end else if (tick) begin
            window_cnt <= window_cnt + 1'b1;
        end
    end

    // clear wins over a new sample in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            peak <= '0;
        end else if (window_clear) begin
            peak <= '0;
        end else if (data_ready && (sample > peak)) begin
            peak <= sample;
        end
    end

    // follows peak until a frame starts, then holds for its three bytes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snapshot <= '0;
        end else if (!frame_busy) begin
            snapshot <= peak;
        end
    end

    // byte formatting from the frozen value
    always_comb begin
        case (word_sel)
            sel_channel: tx_word = channel_letter;
            sel_low:     tx_word = {payload_prefix, snapshot[4:0]};
            sel_high:    tx_word = {payload_prefix, snapshot[9:5]};
            default:     tx_word = 8'h00;
        endcase
    end

    // peak only ever moves up, except right after the window clear
    peak_monotonic_a: assert property (
        @(posedge clk) disable iff (!rst_n) !window_clear |=> (peak >= $past(peak))
    );

endmodule

// File: design/pool_logger_top.sv
// Pool sensor logger top
module pool_logger_top #(
    parameter int tick_cycles  = 6_250_000,
    parameter int peak_window  = 40,
    parameter int clks_per_bit = 434
) (
    input  logic clk,
    input  logic rst_n,
    input  logic adc_bit,
    input  logic adc_bit_valid,
    input  logic data_logging,
    input  logic data_ready,
    input  logic report_req,
    output logic uart_txd,
    output logic frame_busy
);

    import pool_pkg::*;

    word_sel_t  word_sel;
    logic [7:0] tx_word;
    logic       tx_start;
    logic       tx_done;
    logic       tx_busy;

    pool_datapath #(
        .tick_cycles (tick_cycles),
        .peak_window (peak_window)
    ) pool_datapath_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .adc_bit       (adc_bit),
        .adc_bit_valid (adc_bit_valid),
        .data_logging  (data_logging),
        .data_ready    (data_ready),
        .frame_busy    (frame_busy),
        .word_sel      (word_sel),
        .tx_word       (tx_word)
    );

    report_controller report_controller_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .report_req (report_req),
        .tx_done    (tx_done),
        .frame_busy (frame_busy),
        .word_sel   (word_sel),
        .tx_start   (tx_start)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) uart_tx_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_word  (tx_word),
        .uart_txd (uart_txd),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

    // the serializer only runs inside a frame, so the snapshot stays frozen
    tx_inside_frame_a: assert property (
        @(posedge clk) disable iff (!rst_n) tx_busy |-> frame_busy
    );

endmodule

// File: design/pool_pkg.sv
// Pool logger shared definitions
package pool_pkg;

    // width of one adc sample
    localparam int sample_bits = 10;

    // one adc sample as shifted in from the converter
    typedef logic [sample_bits-1:0] sample_t;

    // byte select from the report sequencer to the formatter
    typedef logic [1:0] word_sel_t;

    // select codes, one per byte of the frame plus idle
    // idle puts 0x00 on the word bus
    localparam word_sel_t sel_idle    = 2'd0;
    // channel letter byte
    localparam word_sel_t sel_channel = 2'd1;
    // prefix above sample bits 4..0
    localparam word_sel_t sel_low     = 2'd2;
    // prefix above sample bits 9..5
    localparam word_sel_t sel_high    = 2'd3;

    // ascii "A", the only channel in this build
    localparam logic [7:0] channel_letter = 8'h41;

    // marks a payload byte on the host side
    localparam logic [2:0] payload_prefix = 3'b100;

    // width of the tick counter for the peak window
    localparam int window_bits = 6;

endpackage

// File: design/report_controller.sv
// Report frame sequencer
module report_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                report_req,
    input  logic                tx_done,
    output logic                frame_busy,
    output pool_pkg::word_sel_t word_sel,
    output logic                tx_start
);

    import pool_pkg::*;

    // one state per byte of the frame
    typedef enum logic [1:0] {
        st_idle,
        st_channel,
        st_low,
        st_high
    } state_t;

    state_t state;

    // outputs are registered so the formatter and uart see clean levels
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            frame_busy <= 1'b0;
            word_sel   <= sel_idle;
            tx_start   <= 1'b0;
        end else begin
            // start is a single cycle strobe
            tx_start <= 1'b0;
            case (state)
                st_idle: begin
                    // requests during a frame never get here
                    if (report_req) begin
                        state      <= st_channel;
                        frame_busy <= 1'b1;
                        word_sel   <= sel_channel;
                        tx_start   <= 1'b1;
                    end
                end
                st_channel: begin
                    if (tx_done) begin
                        state    <= st_low;
                        word_sel <= sel_low;
                        tx_start <= 1'b1;
                    end
                end
                st_low: begin
                    if (tx_done) begin
                        state    <= st_high;
                        word_sel <= sel_high;
                        tx_start <= 1'b1;
                    end
                end
                st_high: begin
                    // last byte out, frame ends and snapshot may follow again
                    if (tx_done) begin
                        state      <= st_idle;
                        frame_busy <= 1'b0;
                        word_sel   <= sel_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // a byte is only selected while the frame is marked busy
    sel_within_frame_a: assert property (
        @(posedge clk) disable iff (!rst_n) (word_sel != sel_idle) |-> frame_busy
    );

endmodule

// File: design/tick_divider.sv
// Eighth-second tick divider
module tick_divider #(
    parameter int tick_cycles = 6_250_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    // counter just wide enough for tick_cycles - 1
    localparam int cnt_w = (tick_cycles > 1) ? $clog2(tick_cycles) : 1;

    logic [cnt_w-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == cnt_w'(tick_cycles - 1));

    // free running from reset, tick is registered on the wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= wrap;
            if (wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // window counting downstream relies on single cycle ticks
    tick_single_cycle_a: assert property (
        @(posedge clk) disable iff (!rst_n) tick |=> !tick
    );

endmodule

// File: design/uart_tx.sv
// UART 8N1 transmitter
module uart_tx #(
    parameter int clks_per_bit = 434
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_word,
    output logic       uart_txd,
    output logic       tx_busy,
    output logic       tx_done
);

    localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

    // stop, data lsb first, start; bit 0 is on the line
    logic [9:0]       frame;
    logic [cnt_w-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic             bit_end;

    assign bit_end  = (clk_cnt == cnt_w'(clks_per_bit - 1));
    // ones shift in behind the frame so the line idles high
    assign uart_txd = frame[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame   <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx_busy <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (!tx_busy) begin
                if (tx_start) begin
                    frame   <= {1'b1, tx_word, 1'b0};
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    tx_busy <= 1'b1;
                end
            end else if (bit_end) begin
                clk_cnt <= '0;
                frame   <= {1'b1, frame[9:1]};
                // tenth bit time ends the stop bit
                if (bit_cnt == 4'd9) begin
                    tx_busy <= 1'b0;
                    tx_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // the sequencer must wait for done before the next start
    start_when_idle_a: assert property (
        @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build the pool logger testbench with Verilator, run it, then search the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_pool_logger -o tb_pool_logger \
    && ./obj_dir/tb_pool_logger > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0

// File: sim.f
design/pool_pkg.sv
design/adc_sipo.sv
design/tick_divider.sv
design/pool_datapath.sv
design/report_controller.sv
design/uart_tx.sv
design/pool_logger_top.sv
tb/tb_pool_logger.sv

// File: tb/tb_pool_logger.sv
// Pool logger testbench
module tb_pool_logger;

    import pool_pkg::*;

    localparam int tick_cycles    = 50;
    localparam int peak_window    = 6;
    localparam int clks_per_bit   = 8;
    localparam int drive_delay    = 2;
    localparam int window_cycles  = tick_cycles * peak_window;
    // tick registered on the wrap, counted one edge later, clear one edge after that
    localparam int first_clear    = window_cycles + 2;
    localparam int guard_cycles   = 4;
    localparam int frame_count    = 7;
    // 30 bit times per frame, the window waits, then slack for samples and gaps
    localparam int timeout_cycles = frame_count * 30 * clks_per_bit + 3 * window_cycles + 2000;

    logic clk;
    logic rst_n;
    logic adc_bit;
    logic adc_bit_valid;
    logic data_logging;
    logic data_ready;
    logic report_req;
    logic uart_txd;
    logic frame_busy;

    // reference model state, edge count since reset release
    sample_t     model_shift;
    sample_t     model_peak;
    int          model_cyc;
    logic [31:0] lfsr_state;
    // received bytes and the peak each requested frame should carry
    logic [7:0]  rx_q[$];
    sample_t     exp_q[$];
    int          frames_sent;
    int          frames_checked;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_err_start;
    string       test_name;

    pool_logger_top #(
        .tick_cycles  (tick_cycles),
        .peak_window  (peak_window),
        .clks_per_bit (clks_per_bit)
    ) pool_logger_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .adc_bit       (adc_bit),
        .adc_bit_valid (adc_bit_valid),
        .data_logging  (data_logging),
        .data_ready    (data_ready),
        .report_req    (report_req),
        .uart_txd      (uart_txd),
        .frame_busy    (frame_busy)
    );

    always #10 clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr bit per sample bit, first bit taken lands at the msb
    function automatic sample_t random_sample();
        sample_t v;
        int      b;
        v = '0;
        for (b = 0; b < sample_bits; b++) begin
            v = {v[sample_bits-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // expected byte idx of a frame: letter A, then 100 over each five bit half
    function automatic logic [7:0] frame_byte(input sample_t peak, input int idx);
        case (idx)
            0:       return 8'h41;
            1:       return {3'b100, peak[4:0]};
            default: return {3'b100, peak[9:5]};
        endcase
    endfunction

    // edges from now until the next window clear
    function automatic int cycles_to_clear(input int cyc);
        if (cyc < first_clear) begin
            return first_clear - cyc;
        end
        return window_cycles - ((cyc - first_clear) % window_cycles);
    endfunction

    // peak model, clear wins over a larger sample on the same edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_shift <= '0;
            model_peak  <= '0;
            model_cyc   <= 0;
        end else begin
            model_cyc <= model_cyc + 1;
            if (adc_bit_valid && data_logging) begin
                model_shift <= {model_shift[sample_bits-2:0], adc_bit};
            end
            if (cycles_to_clear(model_cyc) == 1) begin
                model_peak <= '0;
            end else if (data_ready && (model_shift > model_peak)) begin
                model_peak <= model_shift;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    // hold off until a clear that would fall within need cycles has passed
    task automatic avoid_clear(input int need);
        int left;
        left = cycles_to_clear(model_cyc);
        if (left <= need + guard_cycles) begin
            repeat (left + guard_cycles) next_cycle();
        end
    endtask

    // ten bits msb first, then one data_ready strobe
    task automatic send_sample(input sample_t value, input logic logging);
        sample_t bits;
        int      b;
        bits = value;
        avoid_clear(sample_bits + 2);
        data_logging = logging;
        for (b = 0; b < sample_bits; b++) begin
            adc_bit       = bits[sample_bits-1];
            adc_bit_valid = 1'b1;
            bits          = bits << 1;
            next_cycle();
        end
        adc_bit_valid = 1'b0;
        adc_bit       = 1'b0;
        data_logging  = 1'b1;
        data_ready    = 1'b1;
        next_cycle();
        data_ready = 1'b0;
    endtask

    // frame carries the peak as it stands just before the request edge
    task automatic request_report();
        exp_q.push_back(model_peak);
        frames_sent++;
        report_req = 1'b1;
        next_cycle();
        report_req = 1'b0;
    endtask

    task automatic wait_frame();
        while (frame_busy) next_cycle();
        while (frames_checked < frames_sent) next_cycle();
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %0d %s: passed", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, test_name,
                     errors - test_err_start);
        end
    endtask

    // uart receiver, each bit sampled in its middle, lsb first
    initial begin : uart_decoder
        logic [7:0] data;
        int         b;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge uart_txd);
            repeat (clks_per_bit / 2) @(posedge clk);
            assert (uart_txd === 1'b0) else begin
                $display("%0t: uart start bit did not stay low", $time);
                errors++;
            end
            for (b = 0; b < 8; b++) begin
                repeat (clks_per_bit) @(posedge clk);
                data = {uart_txd, data[7:1]};
            end
            repeat (clks_per_bit) @(posedge clk);
            assert (uart_txd === 1'b1) else begin
                $display("%0t: uart stop bit missing", $time);
                errors++;
            end
            rx_q.push_back(data);
        end
    end

    // three bytes make a frame, matched against the oldest request
    initial begin : compare_frames
        sample_t    peak_exp;
        logic [7:0] got;
        logic [7:0] want;
        int         idx;
        forever begin
            @(posedge clk);
            if (rx_q.size() >= 3) begin
                peak_exp = '0;
                assert (exp_q.size() > 0) else begin
                    $display("%0t: frame received without a report request", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    peak_exp = exp_q.pop_front();
                end
                for (idx = 0; idx < 3; idx++) begin
                    got  = rx_q.pop_front();
                    want = frame_byte(peak_exp, idx);
                    checks++;
                    assert (got == want) else begin
                        $display("Mismatch at %0t: byte %0d got 0x%02h expected 0x%02h",
                                 $time, idx, got, want);
                        errors++;
                    end
                end
                frames_checked++;
            end
        end
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog: run timed out after %0d cycles", timeout_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : run_tests
        sample_t v;
        sample_t top;
        int      n;
        clk            = 1'b0;
        rst_n          = 1'b0;
        adc_bit        = 1'b0;
        adc_bit_valid  = 1'b0;
        data_logging   = 1'b1;
        data_ready     = 1'b0;
        report_req     = 1'b0;
        lfsr_state     = 32'h1cd5;
        frames_sent    = 0;
        frames_checked = 0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        repeat (3) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        next_cycle();

        begin_test("reset state and empty report");
        checks++;
        assert (uart_txd === 1'b1 && frame_busy === 1'b0) else begin
            $display("Mismatch at %0t: after reset uart_txd=%b frame_busy=%b",
                     $time, uart_txd, frame_busy);
            errors++;
        end
        request_report();
        wait_frame();
        end_test();

        begin_test("single sample");
        send_sample(random_sample(), 1'b1);
        request_report();
        wait_frame();
        end_test();

        // a smaller sample at the end must leave the maximum alone
        begin_test("maximum of several samples");
        top = '0;
        for (n = 0; n < 6; n++) begin
            v = random_sample();
            if (v > top) begin
                top = v;
            end
            send_sample(v, 1'b1);
        end
        send_sample(top >> 1, 1'b1);
        request_report();
        wait_frame();
        end_test();

        // shifter keeps the last logged sample, data_ready offers it again
        begin_test("bits ignored while not logging");
        send_sample(10'h3ff, 1'b0);
        request_report();
        wait_frame();
        end_test();

        begin_test("peak cleared after the window");
        send_sample(random_sample(), 1'b1);
        repeat (window_cycles + 20) next_cycle();
        request_report();
        wait_frame();
        end_test();

        // start just past a clear so both frames fit in one window
        begin_test("snapshot held during a frame");
        avoid_clear(window_cycles);
        send_sample(10'h055, 1'b1);
        request_report();
        send_sample(10'h2d3, 1'b1);
        assert (frame_busy === 1'b1) else begin
            $display("%0t: larger sample did not land inside the frame", $time);
            errors++;
        end
        wait_frame();
        request_report();
        wait_frame();
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
